// File: Makefile
# Verilator build and run of the polar decoder output stage

VERILATOR  ?= verilator
TOP        := pc_dec_out_tb
RTL_TOP    := pc_dec_out_top
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/pc_dec_bit_buffer.sv
/*
  single bank hard-decision bit buffer for one codeword
  write port from the decoder side, registered read port for the sink
  full flag and frame header latched at frame complete
*/

`default_nettype none
`timescale 1ns/1ps

module pc_dec_bit_buffer
  import pc_dec_pkg::*;
#(
  parameter int pN_MAX = 32,
  parameter int pTAG_W = 4
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // decoder side
  input  logic              wr,
  input  bit_addr_t         waddr,
  input  logic              wdat,
  input  logic              wdone,
  input  logic [pTAG_W-1:0] wtag,
  input  err_t              werr,
  input  dlen_t             wdlen,
  // sink side
  input  bit_addr_t         raddr,
  input  logic              rempty,
  output logic              full,
  output logic              rdat,
  output logic [pTAG_W-1:0] rtag,
  output err_t              rerr,
  output dlen_t             rdlen
);

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  logic [pN_MAX-1:0] mem;

  // decoder side locked out while the sink owns the bank
  logic wr_ok;
  logic done_ok;

  assign wr_ok   = wr & ~full;
  assign done_ok = wdone & ~full;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_ok) begin
        mem[waddr] <= wdat;
      end
      // read data one clock after the address
      rdat <= mem[raddr];
    end
  end

  // --------------------------------------------------------------------------
  // full flag
  // --------------------------------------------------------------------------

  // set by frame complete, cleared by the sink's empty strobe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      full <= 1'b0;
    end else if (iclkena) begin
      if (done_ok) begin
        full <= 1'b1;
      end else if (rempty) begin
        full <= 1'b0;
      end
    end
  end

  // frame header, held while full
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (done_ok) begin
        rtag  <= wtag;
        rerr  <= werr;
        rdlen <= wdlen;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/pc_dec_out_top.sv
/*
  output stage top, bit buffer followed by the sink
  sizes and CRC option set here and passed down
*/

`default_nettype none
`timescale 1ns/1ps

module pc_dec_out_top
  import pc_dec_pkg::*;
#(
  parameter int pN_MAX   = 32,
  parameter bit pUSE_CRC = 1'b1,
  parameter int pTAG_W   = 4
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // decoder write side
  input  logic              wr,
  input  bit_addr_t         waddr,
  input  logic              wdat,
  input  logic              wdone,
  input  logic [pTAG_W-1:0] wtag,
  input  err_t              werr,
  input  dlen_t             wdlen,
  // consumer side
  input  logic              req,
  output logic              busy,
  output logic              sop,
  output logic              val,
  output logic              eop,
  output logic              dat,
  output logic [pTAG_W-1:0] tag,
  output err_t              err,
  output logic              crc_err
);

  // --------------------------------------------------------------------------
  // buffer to sink
  // --------------------------------------------------------------------------

  logic              buf_full;
  logic              buf_rdat;
  logic [pTAG_W-1:0] buf_rtag;
  err_t              buf_rerr;
  dlen_t             buf_rdlen;
  bit_addr_t         sink_raddr;
  logic              sink_rempty;

  pc_dec_bit_buffer #(
    .pN_MAX (pN_MAX),
    .pTAG_W (pTAG_W)
  ) pc_dec_bit_buffer_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .wr      (wr),
    .waddr   (waddr),
    .wdat    (wdat),
    .wdone   (wdone),
    .wtag    (wtag),
    .werr    (werr),
    .wdlen   (wdlen),
    .raddr   (sink_raddr),
    .rempty  (sink_rempty),
    .full    (buf_full),
    .rdat    (buf_rdat),
    .rtag    (buf_rtag),
    .rerr    (buf_rerr),
    .rdlen   (buf_rdlen)
  );

  // read latency of the buffer is part of the sink's 2 ticks
  pc_dec_sink #(
    .pN_MAX   (pN_MAX),
    .pUSE_CRC (pUSE_CRC),
    .pTAG_W   (pTAG_W)
  ) pc_dec_sink_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .dlen    (buf_rdlen),
    .err_in  (buf_rerr),
    .full    (buf_full),
    .rdat    (buf_rdat),
    .rtag    (buf_rtag),
    .rempty  (sink_rempty),
    .raddr   (sink_raddr),
    .req     (req),
    .busy    (busy),
    .sop     (sop),
    .val     (val),
    .eop     (eop),
    .dat     (dat),
    .tag     (tag),
    .err     (err),
    .crc_err (crc_err)
  );

endmodule

`default_nettype wire

// File: design/pc_dec_pkg.sv
/*
  shared sizes and types of the polar decoder output stage
  info bit placement rule (bit reversal of the info index)
  serial CRC6 step, x^6+x^5+1, MSB first, zero start value
*/

`default_nettype none

package pc_dec_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // codeword length in bits
  localparam int cN_MAX  = 32;
  localparam int cADDR_W = $clog2(cN_MAX);

  // 3GPP CRC6
  localparam int cCRC_W  = 6;

  // --------------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------------

  typedef logic [cADDR_W-1:0] bit_addr_t;

  // data bits only, CRC bits not counted
  typedef logic [cADDR_W:0]   dlen_t;

  // decoder metric, carried through untouched
  typedef logic [7:0]         err_t;

  typedef logic [cCRC_W-1:0]  crc_t;

  // x^5 + 1 terms, x^6 implied by the shift out
  localparam crc_t cCRC_POLY = 6'b100001;

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // info bit i lives at bitrev(i) over the address width
  function automatic bit_addr_t info_pos(input bit_addr_t idx);
    bit_addr_t pos;
    pos = '0;
    for (int b = 0; b < cADDR_W; b++) begin
      pos[b] = idx[cADDR_W-1-b];
    end
    return pos;
  endfunction

  // one serial bit into the CRC register
  // the appended CRC is sent MSB first right after the data
  function automatic crc_t crc_step(input crc_t crc, input logic din);
    logic fb;
    crc_t nxt;
    fb  = din ^ crc[cCRC_W-1];
    nxt = {crc[cCRC_W-2:0], 1'b0};
    if (fb) begin
      nxt = nxt ^ cCRC_POLY;
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

// File: design/pc_dec_sink.sv
/*
  output sink of the polar decoder
  reads info bits in bit reversed order, one per request
  sop/val/eop framing, tag and metric pass through
  optional check of the appended CRC6
*/

`default_nettype none
`timescale 1ns/1ps

module pc_dec_sink
  import pc_dec_pkg::*;
#(
  parameter int pN_MAX   = 32,
  parameter bit pUSE_CRC = 1'b0,
  parameter int pTAG_W   = 4
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  // frame header from the buffer
  input  dlen_t             dlen,
  input  err_t              err_in,
  // buffer read side
  input  logic              full,
  input  logic              rdat,
  input  logic [pTAG_W-1:0] rtag,
  output logic              rempty,
  output bit_addr_t         raddr,
  // consumer side
  input  logic              req,
  output logic              busy,
  output logic              sop,
  output logic              val,
  output logic              eop,
  output logic              dat,
  output logic [pTAG_W-1:0] tag,
  output err_t              err,
  output logic              crc_err
);

  localparam int cIDX_W = $clog2(pN_MAX);

  typedef enum logic [1:0] {
    cIDLE,
    cDATA,
    cCRC,
    cDONE
  } state_t;

  state_t state;

  // read counter, done marks the last read of a phase
  dlen_t cnt_val;
  logic  cnt_done;
  dlen_t dlen_r;

  // info index one ahead of raddr
  logic [cIDX_W-1:0] idx_la;

  // 2 tick alignment to the read path
  logic [1:0] val_sr;
  logic [1:0] eop_sr;
  logic [1:0] set_sf;

  logic dat_val;
  logic crc_val;
  crc_t crc;
  crc_t crc_ref;
  crc_t crc_nxt;

  logic start;
  logic rd_acc;
  logic last_data;
  logic last_crc;
  logic val_in;
  logic eop_in;

  assign start     = (state == cIDLE) & full;
  assign rd_acc    = ((state == cDATA) & req) | (state == cCRC);
  assign last_data = (state == cDATA) & req & cnt_done;
  assign last_crc  = (state == cCRC) & cnt_done;

  // with CRC the last data val waits for the end of the CRC read
  assign val_in = pUSE_CRC ? (((state == cDATA) & req & ~cnt_done) | last_crc)
                           : ((state == cDATA) & req);
  assign eop_in = pUSE_CRC ? last_crc : last_data;

  // --------------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= cIDLE;
    end else if (iclkena) begin
      case (state)
        cIDLE : state <= full ? cDATA : cIDLE;
        cDATA : begin
          if (last_data) begin
            state <= pUSE_CRC ? cCRC : cDONE;
          end
        end
        cCRC  : state <= cnt_done ? cDONE : cCRC;
        // hold until the empty strobe has gone out
        cDONE : state <= rempty ? cIDLE : cDONE;
        default : state <= cIDLE;
      endcase
    end
  end

  // one pulse per frame, after the last val
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rempty <= 1'b0;
    end else if (iclkena) begin
      rempty <= (state == cDONE) & ~rempty;
    end
  end

  // --------------------------------------------------------------------------
  // read address and counters
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (state == cIDLE) begin
        dlen_r   <= dlen;
        cnt_val  <= '0;
        cnt_done <= (dlen == dlen_t'(1));
        raddr    <= info_pos('0);
        idx_la   <= cIDX_W'(1);
      end else if (rd_acc) begin
        cnt_val  <= cnt_done ? '0 : (cnt_val + 1'b1);
        if (state == cCRC) begin
          cnt_done <= (cnt_val == dlen_t'(cCRC_W - 2));
        end else begin
          cnt_done <= (cnt_val == dlen_r - dlen_t'(2));
        end
        // CRC bits follow the data in index order
        raddr    <= info_pos(bit_addr_t'(idx_la));
        idx_la   <= idx_la + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // framing, 2 tick latency from request to val
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_sr  <= '0;
      eop_sr  <= '0;
      set_sf  <= '0;
      dat_val <= 1'b0;
      crc_val <= 1'b0;
      busy    <= 1'b0;
      sop     <= 1'b0;
    end else if (iclkena) begin
      val_sr  <= {val_sr[0], val_in};
      eop_sr  <= {eop_sr[0], eop_in};
      set_sf  <= {set_sf[0], start};
      dat_val <= (state == cDATA) & req;
      crc_val <= (state == cCRC);
      // busy spans the frame up to the empty strobe
      if (set_sf[1]) begin
        busy <= 1'b1;
      end else if (rempty) begin
        busy <= 1'b0;
      end
      // sop up until the first val has gone
      if (set_sf[1]) begin
        sop <= 1'b1;
      end else if (val) begin
        sop <= 1'b0;
      end
    end
  end

  assign val = val_sr[1];
  assign eop = eop_sr[1];

  // header at start, data bit one tick after the RAM
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (start) begin
        tag <= rtag;
        err <= err_in;
      end
      // crc reads leave dat on the last data bit
      if (dat_val) begin
        dat <= rdat;
      end
    end
  end

  // --------------------------------------------------------------------------
  // CRC check
  // --------------------------------------------------------------------------

  // received CRC, first bit ends up as MSB
  assign crc_nxt = {crc_ref[cCRC_W-2:0], rdat};

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (start) begin
        crc     <= '0;
        crc_ref <= '0;
      end else begin
        if (dat_val) begin
          crc <= crc_step(crc, rdat);
        end
        if (crc_val) begin
          crc_ref <= crc_nxt;
        end
      end
    end
  end

  // compare on every CRC bit, the last one decides
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      crc_err <= 1'b0;
    end else if (iclkena) begin
      if (!pUSE_CRC || start) begin
        crc_err <= 1'b0;
      end else if (crc_val) begin
        crc_err <= (crc != crc_nxt);
      end
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verification
design/pc_dec_pkg.sv
design/pc_dec_bit_buffer.sv
design/pc_dec_sink.sv
design/pc_dec_out_top.sv
verification/pc_dec_out_checker.sv
verification/pc_dec_out_tb.sv

// File: verification/pc_dec_out_checker.sv
/*
  bound assertions on the sink's framing and flag rules
  val inside busy, eop with val, one cycle empty strobe, sop drop
  codeword length check against the package
*/

`default_nettype none
`timescale 1ns/1ps

module pc_dec_out_checker
  import pc_dec_pkg::*;
#(
  parameter int pN_MAX = 32
) (
  input logic iclk,
  input logic ireset,
  input logic busy,
  input logic sop,
  input logic val,
  input logic eop,
  input logic rempty
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // sink and package must agree on the codeword size
  initial begin
    assert (pN_MAX == cN_MAX) else begin
      $error("pN_MAX does not match the package codeword length");
      fail_cnt++;
    end
  end

  // ---------------------------------------------------------------------------
  // framing
  // ---------------------------------------------------------------------------

  // no data outside a frame
  a_val_in_frame : assert property (@(posedge iclk) disable iff (ireset) val |-> busy)
    else begin
      $error("val high while busy is low");
      fail_cnt++;
    end

  // end of packet only on a data beat
  a_eop_with_val : assert property (@(posedge iclk) disable iff (ireset) eop |-> val)
    else begin
      $error("eop high without val");
      fail_cnt++;
    end

  // sop drops once the first beat is out
  a_sop_drop : assert property (@(posedge iclk) disable iff (ireset) (sop && val) |=> !sop)
    else begin
      $error("sop still high after the first val");
      fail_cnt++;
    end

  // ---------------------------------------------------------------------------
  // buffer release
  // ---------------------------------------------------------------------------

  // single strobe, frame closes on the next clock
  a_rempty_pulse : assert property (@(posedge iclk) disable iff (ireset)
                                    rempty |=> (!rempty && !busy))
    else begin
      $error("rempty held for more than one cycle or busy still high after it");
      fail_cnt++;
    end

endmodule

bind pc_dec_sink pc_dec_out_checker #(
  .pN_MAX (pN_MAX)
) sink_checker_inst (
  .iclk   (iclk),
  .ireset (ireset),
  .busy   (busy),
  .sop    (sop),
  .val    (val),
  .eop    (eop),
  .rempty (rempty)
);

`default_nettype wire

// File: verification/pc_dec_out_tests.svh
/*
  directed tests of the output stage
  frame write, frame run and result check helpers
*/

`ifndef PC_DEC_OUT_TESTS_SVH
`define PC_DEC_OUT_TESTS_SVH

`default_nettype none

  // ---------------------------------------------------------------------------
  // frame helpers, entered and left on a falling edge
  // ---------------------------------------------------------------------------

  task automatic clear_capture();
    got_cnt = 0;
  endtask

  // random data, CRC appended, spare positions random
  task automatic build_frame(input int len, input int flip_idx);
    for (int i = 0; i < cN_MAX; i++) begin
      image[i]    = ($urandom % 2) != 0;
      exp_data[i] = ($urandom % 2) != 0;
    end
    exp_crc = calc_crc(len);
    for (int i = 0; i < len; i++) begin
      image[rev_addr(i)] = exp_data[i];
    end
    // CRC sent MSB first after the data
    for (int j = 0; j < cCRC_W; j++) begin
      image[rev_addr(len + j)] = exp_crc[cCRC_W-1-j];
    end
    // corrupted bit still comes out as stored
    if (flip_idx >= 0) begin
      exp_data[flip_idx]        = ~exp_data[flip_idx];
      image[rev_addr(flip_idx)] = exp_data[flip_idx];
    end
  endtask

  task automatic write_frame(input int len, input logic [cTAG_W-1:0] ftag, input err_t ferr);
    for (int a = 0; a < cN_MAX; a++) begin
      wr    = 1'b1;
      waddr = bit_addr_t'(a);
      wdat  = image[a];
      @(negedge iclk);
    end
    wr    = 1'b0;
    wdone = 1'b1;
    wtag  = ftag;
    werr  = ferr;
    wdlen = dlen_t'(len);
    @(negedge iclk);
    wdone = 1'b0;
  endtask

  task automatic wait_frame_done(input string name);
    int t;
    t = 0;
    while (!busy) begin
      @(negedge iclk);
      t++;
      if (t > cTIMEOUT) begin
        $display("timeout in %s: busy never went high", name);
        fail_now();
      end
    end
    t = 0;
    while (busy) begin
      @(negedge iclk);
      t++;
      if (t > cTIMEOUT) begin
        $display("timeout in %s: busy never went low", name);
        fail_now();
      end
    end
  endtask

  task automatic check_frame(input string name, input int len,
                             input logic [cTAG_W-1:0] ftag, input err_t ferr,
                             input logic exp_crc_err);
    compare_len(name, dlen_t'(len), dlen_t'(got_cnt));
    for (int i = 0; i < len; i++) begin
      compare_bit(name, i, exp_data[i], got_bits[i]);
      compare_flag(name, "sop", i == 0, got_sop[i]);
      compare_flag(name, "eop", i == len - 1, got_eop[i]);
    end
    compare_tag(name, ftag, tag);
    compare_err(name, ferr, err);
    compare_flag(name, "crc_err", exp_crc_err, crc_err);
  endtask

  task automatic run_frame(input string name, input int len, input logic [cTAG_W-1:0] ftag,
                           input err_t ferr, input int flip_idx, input bit rand_req);
    logic frame_end;
    frame_end = 1'b0;
    clear_capture();
    build_frame(len, flip_idx);
    req = !rand_req;
    write_frame(len, ftag, ferr);
    if (rand_req) begin
      // consumer stalls about half the time
      fork
        begin
          wait_frame_done(name);
          frame_end = 1'b1;
        end
        begin
          while (!frame_end) begin
            req = ($urandom % 2) != 0;
            @(negedge iclk);
          end
        end
      join
    end else begin
      wait_frame_done(name);
    end
    check_frame(name, len, ftag, ferr, flip_idx >= 0);
    req = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------

  task automatic test_reset();
    compare_flag("reset", "busy", 1'b0, busy);
    compare_flag("reset", "sop", 1'b0, sop);
    compare_flag("reset", "val", 1'b0, val);
    compare_flag("reset", "eop", 1'b0, eop);
    compare_flag("reset", "crc_err", 1'b0, crc_err);
  endtask

  task automatic test_extract();
    run_frame("extract", 20, 4'h5, 8'h3c, -1, 1'b0);
  endtask

  task automatic test_backpressure();
    run_frame("backpressure", 24, 4'ha, 8'h81, -1, 1'b1);
    run_frame("backpressure_full", 26, 4'h6, 8'h47, -1, 1'b1);
  endtask

  task automatic test_crc_error();
    run_frame("crc_error", 16, 4'h3, 8'hf0, int'($urandom % 16), 1'b0);
    // flag must clear on the next good frame
    run_frame("crc_recover", 12, 4'h9, 8'h0f, -1, 1'b0);
  endtask

  task automatic test_header_pass();
    int lens [0:2];
    lens[0] = 1;
    lens[1] = 8;
    lens[2] = 26;
    for (int k = 0; k < 3; k++) begin
      run_frame($sformatf("header_len_%0d", lens[k]), lens[k], cTAG_W'($urandom),
                err_t'($urandom), -1, 1'b0);
    end
  endtask

  // next wdone follows straight after busy falls
  task automatic test_back_to_back();
    for (int k = 0; k < 4; k++) begin
      run_frame($sformatf("back_to_back_%0d", k), 1 + int'($urandom % 26),
                cTAG_W'($urandom), err_t'($urandom), -1, 1'b0);
    end
  endtask

`default_nettype wire

`endif

// File: verification/pc_dec_out_tb.sv
/*
  testbench top of the polar decoder output stage
  clock, reset, DUT, frame model and output capture
  compare tasks and the test sequence
*/

`default_nettype none
`timescale 1ns/1ps

module pc_dec_out_tb
  import pc_dec_pkg::*;
();

  localparam int cTAG_W   = 4;
  localparam int cCAP     = 64;
  localparam int cTIMEOUT = 2000;

  // x^6 + x^5 + 1
  localparam logic [cCRC_W:0] cGEN = 7'b1100001;

  logic              iclk;
  logic              ireset;
  logic              iclkena;
  logic              wr;
  bit_addr_t         waddr;
  logic              wdat;
  logic              wdone;
  logic [cTAG_W-1:0] wtag;
  err_t              werr;
  dlen_t             wdlen;
  logic              req;
  logic              busy;
  logic              sop;
  logic              val;
  logic              eop;
  logic              dat;
  logic [cTAG_W-1:0] tag;
  err_t              err;
  logic              crc_err;

  // frame model, info bits in order and the codeword image
  logic              exp_data [0:cN_MAX-1];
  logic [cN_MAX-1:0] image;
  crc_t              exp_crc;

  // output capture, one entry per val
  int         got_cnt;
  logic       got_bits [0:cCAP-1];
  logic       got_sop  [0:cCAP-1];
  logic       got_eop  [0:cCAP-1];
  logic [1:0] req_pos;

  pc_dec_out_top #(
    .pN_MAX   (cN_MAX),
    .pUSE_CRC (1'b1),
    .pTAG_W   (cTAG_W)
  ) pc_dec_out_top_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .wr      (wr),
    .waddr   (waddr),
    .wdat    (wdat),
    .wdone   (wdone),
    .wtag    (wtag),
    .werr    (werr),
    .wdlen   (wdlen),
    .req     (req),
    .busy    (busy),
    .sop     (sop),
    .val     (val),
    .eop     (eop),
    .dat     (dat),
    .tag     (tag),
    .err     (err),
    .crc_err (crc_err)
  );

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;
  end

  // ---------------------------------------------------------------------------
  // failure handling and compare tasks
  // ---------------------------------------------------------------------------

  task automatic fail_now();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_bit(input string name, input int idx,
                             input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s: dat bit %0d expected %b actual %b", name, idx, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic compare_tag(input string name, input logic [cTAG_W-1:0] exp_v,
                             input logic [cTAG_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s: tag expected %h actual %h", name, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic compare_err(input string name, input err_t exp_v, input err_t act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s: err expected %h actual %h", name, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic compare_flag(input string name, input string what,
                              input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s: %s expected %b actual %b", name, what, exp_v, act_v);
      fail_now();
    end
  endtask

  task automatic compare_len(input string name, input dlen_t exp_v, input dlen_t act_v);
    if (act_v !== exp_v) begin
      $display("ERROR %s: val count expected %0d actual %0d", name, exp_v, act_v);
      fail_now();
    end
  endtask

  // ---------------------------------------------------------------------------
  // frame model
  // ---------------------------------------------------------------------------

  // info index to codeword address, LSB of the index becomes the MSB
  function automatic bit_addr_t rev_addr(input int idx);
    int        v;
    bit_addr_t r;
    v = idx;
    r = '0;
    for (int b = 0; b < cADDR_W; b++) begin
      r = {r[cADDR_W-2:0], v[0]};
      v = v >> 1;
    end
    return r;
  endfunction

  // long division of data * x^6 by the generator
  function automatic crc_t calc_crc(input int len);
    logic [cCRC_W:0] rem;
    logic            b;
    rem = '0;
    for (int i = 0; i < len + cCRC_W; i++) begin
      b   = (i < len) ? exp_data[i] : 1'b0;
      rem = {rem[cCRC_W-1:0], b};
      if (rem[cCRC_W]) begin
        rem = rem ^ cGEN;
      end
    end
    return rem[cCRC_W-1:0];
  endfunction

  // ---------------------------------------------------------------------------
  // output capture
  // ---------------------------------------------------------------------------

  always @(posedge iclk) begin
    req_pos <= {req_pos[0], req};
  end

  always @(negedge iclk) begin
    if (val) begin
      if (got_cnt >= cCAP) begin
        $display("more val pulses than any frame can carry");
        fail_now();
      end
      // a data beat needs a request two clocks back
      if (!eop && !req_pos[1]) begin
        $display("val without a request two clocks earlier");
        fail_now();
      end
      got_bits[got_cnt] = dat;
      got_sop[got_cnt]  = sop;
      got_eop[got_cnt]  = eop;
      got_cnt           = got_cnt + 1;
    end
  end

  always @(negedge iclk) begin
    if (pc_dec_out_top_inst.pc_dec_sink_inst.sink_checker_inst.fail_cnt != 0) begin
      $display("bound checker reported an assertion failure");
      fail_now();
    end
  end

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial begin
    void'($urandom(71));
    ireset  = 1'b1;
    iclkena = 1'b1;
    wr      = 1'b0;
    waddr   = '0;
    wdat    = 1'b0;
    wdone   = 1'b0;
    wtag    = '0;
    werr    = '0;
    wdlen   = '0;
    req     = 1'b0;
    req_pos = '0;
    got_cnt = 0;
    repeat (8) @(negedge iclk);
    ireset = 1'b0;
    @(negedge iclk);
    test_reset();
    test_extract();
    test_backpressure();
    test_crc_error();
    test_header_pass();
    test_back_to_back();
    if (pc_dec_out_top_inst.pc_dec_sink_inst.sink_checker_inst.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("bound checker reported an assertion failure");
      fail_now();
    end
  end

  `include "pc_dec_out_tests.svh"

endmodule

`default_nettype wire
